//--- src/ahb_dec_pkg.sv
// Shared definitions for the AHB matrix decoder stage
// Address map is fixed here and covers HADDR[31:10] only
// Regions may overlap and the lowest port number wins
// Port codes above 5 other than DEFAULT_PORT are illegal

package ahb_dec_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int NUM_PORTS  = 6;      // Output ports of the matrix
    localparam int DATA_W     = 32;     // HRDATA width
    localparam int DEC_ADDR_W = 22;     // HADDR[31:10]

    // Data-phase target code
    typedef logic [3:0] port_code_t;

    localparam port_code_t DEFAULT_PORT = 4'd8;   // Local default slave

    // --------------------
    // Address map
    // --------------------
    // Inclusive bounds on HADDR[31:10], indexed by port
    localparam logic [DEC_ADDR_W-1:0] REGION_LO [0:NUM_PORTS-1] = '{
        22'h000000,     // Port 0
        22'h080000,     // Port 1
        22'h100000,     // Port 2
        22'h100040,     // Port 3
        22'h100020,     // Port 4
        22'h100080      // Port 5
    };

    localparam logic [DEC_ADDR_W-1:0] REGION_HI [0:NUM_PORTS-1] = '{
        22'h0003ff,     // Port 0
        22'h0803ff,     // Port 1
        22'h100017,     // Port 2
        22'h100043,     // Port 3
        22'h100020,     // Port 4, single 1 KB block
        22'h100081      // Port 5
    };

    // HTRANS encodings
    localparam logic [1:0] TRANS_IDLE   = 2'b00;
    localparam logic [1:0] TRANS_BUSY   = 2'b01;
    localparam logic [1:0] TRANS_NONSEQ = 2'b10;
    localparam logic [1:0] TRANS_SEQ    = 2'b11;

    // HRESP encodings
    localparam logic [1:0] RESP_OKAY  = 2'b00;
    localparam logic [1:0] RESP_ERROR = 2'b01;

    // --------------------
    // Bundles
    // --------------------
    typedef struct packed {
        logic                  sel;     // HSEL from input stage
        logic [DEC_ADDR_W-1:0] addr;    // HADDR[31:10]
        logic [1:0]            trans;   // HTRANS
    } ahb_req_t;

    typedef struct packed {
        logic              readyout;    // HREADYOUT
        logic [1:0]        resp;        // HRESP
        logic [DATA_W-1:0] rdata;       // HRDATA
    } slave_rsp_t;

endpackage

//--- src/addr_region_decode.sv
// Address-phase decode, purely combinational
// IDLE transfers stay on the current data-phase port so that an
// IDLE between bursts does not hop to another output stage
// Unmapped addresses go to the default slave

`timescale 1ns/1ns

module addr_region_decode (
    input  ahb_dec_pkg::ahb_req_t                req,          // Address-phase request
    input  ahb_dec_pkg::port_code_t              data_port,    // Current data-phase port
    input  logic [ahb_dec_pkg::NUM_PORTS-1:0]    slv_active,   // Per-port active flags
    output ahb_dec_pkg::port_code_t              addr_port,    // Decoded target
    output logic [ahb_dec_pkg::NUM_PORTS-1:0]    sel,          // One-hot port select
    output logic                                 sel_dft,      // Default slave select
    output logic                                 active        // Active flag of target
);

    logic [ahb_dec_pkg::NUM_PORTS-1:0] region_hit;   // Address inside region k
    logic [ahb_dec_pkg::NUM_PORTS-1:0] hold_hit;     // IDLE on current port k
    logic [ahb_dec_pkg::NUM_PORTS-1:0] port_hit;     // Either condition
    logic                              is_idle;

    assign is_idle = (req.trans == ahb_dec_pkg::TRANS_IDLE);

    // --------------------
    // Region compare
    // --------------------
    always_comb
    begin
        for (int k = 0; k < ahb_dec_pkg::NUM_PORTS; k++)
        begin
            region_hit[k] = (req.addr >= ahb_dec_pkg::REGION_LO[k]) &&
                            (req.addr <= ahb_dec_pkg::REGION_HI[k]);
            // Keep the data-phase port across IDLE
            hold_hit[k]   = is_idle &&
                            (data_port == ahb_dec_pkg::port_code_t'(k));
        end
    end

    assign port_hit = region_hit | hold_hit;

    // --------------------
    // Priority encode
    // --------------------
    // Scan downwards so the lowest qualifying port is the last write
    always_comb
    begin
        addr_port = ahb_dec_pkg::DEFAULT_PORT;   // Nothing mapped
        for (int k = ahb_dec_pkg::NUM_PORTS - 1; k >= 0; k--)
        begin
            if (port_hit[k])
                addr_port = ahb_dec_pkg::port_code_t'(k);
        end
    end

    // --------------------
    // Select outputs
    // --------------------
    always_comb
    begin
        for (int k = 0; k < ahb_dec_pkg::NUM_PORTS; k++)
        begin
            sel[k] = req.sel && (addr_port == ahb_dec_pkg::port_code_t'(k));
        end
        sel_dft = req.sel && (addr_port == ahb_dec_pkg::DEFAULT_PORT);
    end

    // Active flag of the decoded target, not gated by HSEL
    always_comb
    begin
        active = 1'b0;                           // Illegal code
        if (addr_port == ahb_dec_pkg::DEFAULT_PORT)
            active = 1'b1;                       // Default slave always active
        for (int k = 0; k < ahb_dec_pkg::NUM_PORTS; k++)
        begin
            if (addr_port == ahb_dec_pkg::port_code_t'(k))
                active = slv_active[k];
        end
    end

endmodule

//--- src/data_phase_route.sv
// Data-phase port register and response mux
// Register advances only when HREADYS is high, so it holds through wait states
// Illegal port codes return a zero-wait OKAY with zero data

`timescale 1ns/1ns

module data_phase_route (
    input  logic                                       HCLK,
    input  logic                                       HRESETn,     // Sync, active low
    input  logic                                       HREADYS,     // Transfer done
    input  ahb_dec_pkg::port_code_t                    addr_port,   // From address decode
    input  ahb_dec_pkg::slave_rsp_t [ahb_dec_pkg::NUM_PORTS-1:0] slv_rsp,
    input  ahb_dec_pkg::slave_rsp_t                    dft_rsp,     // Default slave response
    output ahb_dec_pkg::port_code_t                    data_port,   // Registered target
    output logic                                       HREADYOUTS,
    output logic [1:0]                                 HRESPS,
    output logic [ahb_dec_pkg::DATA_W-1:0]             HRDATAS
);

    ahb_dec_pkg::slave_rsp_t rsp_mux;    // Response of data-phase target

    // --------------------
    // Port register
    // --------------------
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            data_port <= '0;             // Port 0 out of reset
        else if (HREADYS)
            data_port <= addr_port;      // Address phase moves to data phase
    end

    // --------------------
    // Response mux
    // --------------------
    always_comb
    begin
        // Fallback for illegal codes
        rsp_mux.readyout = 1'b1;
        rsp_mux.resp     = ahb_dec_pkg::RESP_OKAY;
        rsp_mux.rdata    = '0;

        if (data_port == ahb_dec_pkg::DEFAULT_PORT)
            rsp_mux = dft_rsp;

        for (int k = 0; k < ahb_dec_pkg::NUM_PORTS; k++)
        begin
            if (data_port == ahb_dec_pkg::port_code_t'(k))
                rsp_mux = slv_rsp[k];
        end
    end

    assign HREADYOUTS = rsp_mux.readyout;
    assign HRESPS     = rsp_mux.resp;
    assign HRDATAS    = rsp_mux.rdata;   // Zero from default slave

endmodule

//--- src/default_slave.sv
// Local slave behind unmapped addresses
// NONSEQ and SEQ get the AHB two-cycle ERROR, IDLE and BUSY get zero-wait OKAY
// Assumes the input stage holds HREADYS low while HREADYOUT is low
// Read data is always zero

`timescale 1ns/1ns

module default_slave (
    input  logic                    HCLK,
    input  logic                    HRESETn,     // Sync, active low
    input  logic                    sel_dft,     // Selected in address phase
    input  logic [1:0]              trans,       // HTRANS
    input  logic                    HREADYS,     // Transfer done
    output ahb_dec_pkg::slave_rsp_t dft_rsp
);

    logic err_start;    // Accepted NONSEQ/SEQ to this slave
    logic err_wait;     // First ERROR cycle, HREADYOUT low
    logic err_last;     // Second ERROR cycle, HREADYOUT high

    // Only real transfers raise an error
    always_comb
    begin
        err_start = 1'b0;
        case (trans)
            ahb_dec_pkg::TRANS_IDLE,
            ahb_dec_pkg::TRANS_BUSY:   err_start = 1'b0;
            ahb_dec_pkg::TRANS_NONSEQ,
            ahb_dec_pkg::TRANS_SEQ:    err_start = sel_dft && HREADYS;
            default:                   err_start = 1'b0;
        endcase
    end

    // --------------------
    // Error sequencer
    // --------------------
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            err_wait <= 1'b0;
            err_last <= 1'b0;
        end
        else
        begin
            err_wait <= err_start;   // Wait cycle follows acceptance
            err_last <= err_wait;    // Completion cycle follows wait
        end
    end

    always_comb
    begin
        dft_rsp.readyout = ~err_wait;
        dft_rsp.resp     = (err_wait || err_last) ? ahb_dec_pkg::RESP_ERROR
                                                  : ahb_dec_pkg::RESP_OKAY;
        dft_rsp.rdata    = '0;
    end

endmodule

//--- src/ahb_decoder_stage.sv
// Decoder stage of one AHB bus matrix input port
// Address phase decodes to one of six output ports or the default slave
// Data phase routes the chosen port's response back to the input stage
// Synchronous active-low reset, one clock domain

`timescale 1ns/1ns

module ahb_decoder_stage (
    input  logic                                       HCLK,
    input  logic                                       HRESETn,

    // From input stage
    input  ahb_dec_pkg::ahb_req_t                      req,
    input  logic                                       HREADYS,

    // From output stages
    input  ahb_dec_pkg::slave_rsp_t [ahb_dec_pkg::NUM_PORTS-1:0] slv_rsp,
    input  logic [ahb_dec_pkg::NUM_PORTS-1:0]          slv_active,

    // Port selects
    output logic [ahb_dec_pkg::NUM_PORTS-1:0]          sel,
    output logic                                       active,

    // Back to input stage
    output logic                                       HREADYOUTS,
    output logic [1:0]                                 HRESPS,
    output logic [ahb_dec_pkg::DATA_W-1:0]             HRDATAS
);

    ahb_dec_pkg::port_code_t addr_port;   // Address-phase target
    ahb_dec_pkg::port_code_t data_port;   // Data-phase target
    logic                    sel_dft;     // Default slave HSEL
    ahb_dec_pkg::slave_rsp_t dft_rsp;     // Default slave response

    // --------------------
    // Address phase
    // --------------------
    addr_region_decode u_addr_region_decode (
        .req        (req),
        .data_port  (data_port),    // Needed for IDLE hold
        .slv_active (slv_active),
        .addr_port  (addr_port),
        .sel        (sel),
        .sel_dft    (sel_dft),
        .active     (active)
    );

    // Unmapped accesses land here
    default_slave u_default_slave (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .sel_dft    (sel_dft),
        .trans      (req.trans),
        .HREADYS    (HREADYS),
        .dft_rsp    (dft_rsp)
    );

    // --------------------
    // Data phase
    // --------------------
    data_phase_route u_data_phase_route (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HREADYS    (HREADYS),
        .addr_port  (addr_port),
        .slv_rsp    (slv_rsp),
        .dft_rsp    (dft_rsp),
        .data_port  (data_port),
        .HREADYOUTS (HREADYOUTS),
        .HRESPS     (HRESPS),
        .HRDATAS    (HRDATAS)
    );

endmodule

//--- verif/ahb_decoder_stage_sva.sv
// Bound checks on the decoder stage outputs
// Attached to every ahb_decoder_stage instance
// HSEL gating is checked through reset as well

`timescale 1ns/1ns

module ahb_decoder_stage_sva (
    input logic                              HCLK,
    input logic                              HRESETn,
    input ahb_dec_pkg::ahb_req_t             req,
    input logic [ahb_dec_pkg::NUM_PORTS-1:0] sel,
    input logic                              HREADYOUTS,
    input logic [1:0]                        HRESPS
);

    // --------------------
    // Select
    // --------------------
    a_sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(sel))
        else $error("sel has more than one bit set");

    a_sel_gated: assert property (@(posedge HCLK) !req.sel |-> (sel == '0))
        else $error("sel set while HSEL is low");

    // --------------------
    // Response
    // --------------------
    // ERROR completion needs the ERROR wait cycle right before it
    a_err_two_cycle: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (HREADYOUTS && HRESPS == ahb_dec_pkg::RESP_ERROR) |->
            ($past(HRESPS) == ahb_dec_pkg::RESP_ERROR && !$past(HREADYOUTS)))
        else $error("ERROR completion without a preceding wait cycle");

endmodule

bind ahb_decoder_stage ahb_decoder_stage_sva u_sva (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .req        (req),
    .sel        (sel),
    .HREADYOUTS (HREADYOUTS),
    .HRESPS     (HRESPS)
);

//--- verif/tb_ahb_decoder_stage.sv
// Testbench for the AHB decoder stage
// Random requests aimed in and around the fixed address map
// Slave models start a two-cycle ERROR only on the current data-phase port
// Outputs are compared on the falling edge against reference functions
// The first mismatch stops the run

`timescale 1ns/1ns

module tb_ahb_decoder_stage;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_XFERS    = 3000;
    localparam int SEED         = 7;
    localparam int TIMEOUT_NS   = NUM_XFERS * 3 * CLK_PERIOD * 12 / 10;   // 3 cycles per transfer, +20%
    localparam int NP           = ahb_dec_pkg::NUM_PORTS;
    localparam logic [ahb_dec_pkg::DEC_ADDR_W-1:0] ADDR_ONE = 1;

    // DUT signals
    logic                             HCLK;
    logic                             HRESETn;
    ahb_dec_pkg::ahb_req_t            req;
    logic                             HREADYS;
    ahb_dec_pkg::slave_rsp_t [NP-1:0] slv_rsp;
    logic [NP-1:0]                    slv_active;
    logic [NP-1:0]                    sel;
    logic                             active;
    logic                             HREADYOUTS;
    logic [1:0]                       HRESPS;
    logic [ahb_dec_pkg::DATA_W-1:0]   HRDATAS;

    // Model state, advanced on the falling edge
    ahb_dec_pkg::port_code_t exp_port = '0;   // Data-phase port
    logic                    exp_wait = 1'b0; // Default slave, ERROR with wait
    logic                    exp_last = 1'b0; // Default slave, ERROR completion
    logic [NP-1:0]           err_pend = '0;   // Slave owes the ERROR completion
    logic                    checks_on = 1'b0;
    int                      accepted  = 0;   // Address phases taken
    int                      err_count = 0;
    int                      n_hold    = 0;   // IDLE holds seen
    int                      n_dft_err = 0;   // Default slave ERROR waits seen
    int                      n_dft_ok  = 0;   // IDLE/BUSY accepted by default slave

    // Compare process scratch
    ahb_dec_pkg::port_code_t dec_port;
    logic [NP-1:0]           want_sel;
    logic                    want_act;
    ahb_dec_pkg::slave_rsp_t want_rsp;
    logic                    next_wait;
    ahb_dec_pkg::ahb_req_t   nonseq_req;      // Same request decoded by address only
    ahb_dec_pkg::slave_rsp_t [NP-1:0] rsp_scratch;

    ahb_decoder_stage u_dut (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .req        (req),
        .HREADYS    (HREADYS),
        .slv_rsp    (slv_rsp),
        .slv_active (slv_active),
        .sel        (sel),
        .active     (active),
        .HREADYOUTS (HREADYOUTS),
        .HRESPS     (HRESPS),
        .HRDATAS    (HRDATAS)
    );

    initial
    begin
        HCLK = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) HCLK = ~HCLK;
        end
    end

    // --------------------
    // Failure reporting
    // --------------------
    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic report_mismatch(string what, logic [31:0] want, logic [31:0] got);
        err_count++;
        $display("ERR @%0t ns: %s mismatch, expected %h, got %h", $time, what, want, got);
        stop_on_failure();
    endtask

    // --------------------
    // Reference functions
    // --------------------
    // Lowest port hit by region, or held by IDLE, else the default slave
    function automatic ahb_dec_pkg::port_code_t expected_port(ahb_dec_pkg::ahb_req_t r,
                                                             ahb_dec_pkg::port_code_t dp);
        logic in_region;
        logic held;
        for (int k = 0; k < NP; k++)
        begin
            in_region = (r.addr >= ahb_dec_pkg::REGION_LO[k]) &&
                        (r.addr <= ahb_dec_pkg::REGION_HI[k]);
            held      = (r.trans == ahb_dec_pkg::TRANS_IDLE) &&
                        (dp == ahb_dec_pkg::port_code_t'(k));
            if (in_region || held)
                return ahb_dec_pkg::port_code_t'(k);
        end
        return ahb_dec_pkg::DEFAULT_PORT;
    endfunction

    function automatic logic [NP-1:0] expected_sel(ahb_dec_pkg::ahb_req_t r,
                                                   ahb_dec_pkg::port_code_t p);
        logic [NP-1:0] s;
        s = '0;
        if (r.sel && (p < ahb_dec_pkg::port_code_t'(NP)))
            s = {{(NP-1){1'b0}}, 1'b1} << p;   // Nothing for the default slave
        return s;
    endfunction

    function automatic logic expected_active(ahb_dec_pkg::port_code_t p, logic [NP-1:0] act);
        if (p == ahb_dec_pkg::DEFAULT_PORT)
            return 1'b1;
        return act[p[2:0]];
    endfunction

    function automatic ahb_dec_pkg::slave_rsp_t expected_rsp(ahb_dec_pkg::port_code_t p,
            ahb_dec_pkg::slave_rsp_t [NP-1:0] rs, logic w, logic l);
        ahb_dec_pkg::slave_rsp_t r;
        if (p == ahb_dec_pkg::DEFAULT_PORT)
        begin
            r.rdata    = '0;
            r.readyout = 1'b1;                   // Zero-wait OKAY by default
            r.resp     = ahb_dec_pkg::RESP_OKAY;
            if (w)
            begin
                r.readyout = 1'b0;               // First ERROR cycle waits
                r.resp     = ahb_dec_pkg::RESP_ERROR;
            end
            else if (l)
                r.resp = ahb_dec_pkg::RESP_ERROR;   // Second ERROR cycle completes
        end
        else
            r = rs[p[2:0]];
        return r;
    endfunction

    // --------------------
    // Stimulus helpers
    // --------------------
    // Mostly inside a region, some just outside, some anywhere
    function automatic ahb_dec_pkg::ahb_req_t make_request();
        ahb_dec_pkg::ahb_req_t r;
        logic [31:0]           rnd;
        logic [31:0]           off;
        int                    k;
        int unsigned           span;
        rnd  = $urandom;
        k    = $urandom_range(NP - 1, 0);
        span = ahb_dec_pkg::REGION_HI[k] - ahb_dec_pkg::REGION_LO[k] + 1;
        if (rnd[3:0] < 4'd10)
        begin
            off    = $urandom % span;
            r.addr = ahb_dec_pkg::REGION_LO[k] + off[ahb_dec_pkg::DEC_ADDR_W-1:0];
        end
        else if (rnd[3:0] < 4'd13)
            r.addr = rnd[4] ? ahb_dec_pkg::REGION_HI[k] + ADDR_ONE    // One block above
                            : ahb_dec_pkg::REGION_LO[k] - ADDR_ONE;   // One block below
        else
        begin
            off    = $urandom;
            r.addr = off[ahb_dec_pkg::DEC_ADDR_W-1:0];
        end
        case (rnd[7:5])
            3'd0, 3'd1, 3'd2: r.trans = ahb_dec_pkg::TRANS_IDLE;
            3'd3:             r.trans = ahb_dec_pkg::TRANS_BUSY;
            3'd7:             r.trans = ahb_dec_pkg::TRANS_SEQ;
            default:          r.trans = ahb_dec_pkg::TRANS_NONSEQ;
        endcase
        r.sel = (rnd[11:8] != 4'd0);   // HSEL low one time in sixteen
        return r;
    endfunction

    task automatic drive_slaves(logic allow_err, output ahb_dec_pkg::slave_rsp_t [NP-1:0] rs);
        logic [31:0] rnd;
        for (int k = 0; k < NP; k++)
        begin
            rnd            = $urandom;
            rs[k].rdata    = $urandom;
            rs[k].resp     = ahb_dec_pkg::RESP_OKAY;
            rs[k].readyout = (rnd[1:0] != 2'b00);              // Wait one time in four
            if (err_pend[k])
            begin
                rs[k].readyout = 1'b1;                         // ERROR completion
                rs[k].resp     = ahb_dec_pkg::RESP_ERROR;
                err_pend[k]    = 1'b0;
            end
            else if (allow_err && exp_port == ahb_dec_pkg::port_code_t'(k) &&
                     rnd[7:4] == 4'd0)
            begin
                rs[k].readyout = 1'b0;                         // ERROR wait cycle
                rs[k].resp     = ahb_dec_pkg::RESP_ERROR;
                err_pend[k]    = 1'b1;
            end
        end
        rnd = $urandom;
        slv_rsp    <= rs;
        slv_active <= rnd[NP-1:0];
    endtask

    task automatic drive_cycle();
        ahb_dec_pkg::slave_rsp_t [NP-1:0] rs;
        ahb_dec_pkg::slave_rsp_t          pred;
        logic [31:0]                      rnd;
        logic                             ready;
        drive_slaves(1'b1, rs);
        pred  = expected_rsp(exp_port, rs, exp_wait, exp_last);
        rnd   = $urandom;
        ready = pred.readyout && (rnd[2:0] != 3'd0);   // Stall on wait, else mostly go
        req     <= make_request();
        HREADYS <= ready;
        if (ready)
            accepted++;
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin
        void'($urandom(SEED));
        HRESETn    = 1'b0;
        req        = '0;
        HREADYS    = 1'b0;
        slv_rsp    = '0;
        slv_active = '0;
        repeat (RESET_CYCLES)
        begin
            @(posedge HCLK);
            checks_on = 1'b1;
            drive_slaves(1'b0, rsp_scratch);   // OKAY only, req idle with HSEL low
        end
        HRESETn <= 1'b1;

        while (accepted < NUM_XFERS)
        begin
            @(posedge HCLK);
            drive_cycle();
        end
        repeat (4)                             // Drain the last data phase
        begin
            @(posedge HCLK);
            drive_cycle();
        end
        @(negedge HCLK);

        assert (n_hold > 0 && n_dft_err > 0 && n_dft_ok > 0)
        else
        begin
            $display("Stimulus missed IDLE hold or default slave OKAY/ERROR cases");
            stop_on_failure();
        end

        if (err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: run did not finish within %0d ns", TIMEOUT_NS);
        stop_on_failure();
    end

    // --------------------
    // Compare
    // --------------------
    always @(negedge HCLK)
    begin
        if (checks_on)
        begin
            if (!HRESETn)
            begin
                exp_port = '0;                 // Reset state of the data phase
                exp_wait = 1'b0;
                exp_last = 1'b0;
            end
            dec_port = expected_port(req, exp_port);
            want_sel = expected_sel(req, dec_port);
            want_act = expected_active(dec_port, slv_active);
            want_rsp = expected_rsp(exp_port, slv_rsp, exp_wait, exp_last);

            assert (sel === want_sel) else report_mismatch("sel", 32'(want_sel), 32'(sel));
            assert (active === want_act)
                else report_mismatch("active", 32'(want_act), 32'(active));
            assert (HREADYOUTS === want_rsp.readyout)
                else report_mismatch("HREADYOUTS", 32'(want_rsp.readyout), 32'(HREADYOUTS));
            assert (HRESPS === want_rsp.resp)
                else report_mismatch("HRESPS", 32'(want_rsp.resp), 32'(HRESPS));
            assert (HRDATAS === want_rsp.rdata)
                else report_mismatch("HRDATAS", want_rsp.rdata, HRDATAS);

            if (HRESETn)
            begin
                nonseq_req       = req;
                nonseq_req.trans = ahb_dec_pkg::TRANS_NONSEQ;
                if (req.sel && dec_port != expected_port(nonseq_req, exp_port))
                    n_hold++;                  // IDLE hold decided the target
                if (exp_wait)
                    n_dft_err++;
                if (HREADYS && req.sel && dec_port == ahb_dec_pkg::DEFAULT_PORT &&
                    !req.trans[1])
                    n_dft_ok++;
                // Accepted NONSEQ/SEQ to default slave starts the ERROR pair
                next_wait = HREADYS && req.sel && dec_port == ahb_dec_pkg::DEFAULT_PORT &&
                            (req.trans == ahb_dec_pkg::TRANS_NONSEQ ||
                             req.trans == ahb_dec_pkg::TRANS_SEQ);
                if (HREADYS)
                    exp_port = dec_port;       // Address phase becomes data phase
                exp_last = exp_wait;
                exp_wait = next_wait;
            end
        end
    end

endmodule

//--- src.f
src/ahb_dec_pkg.sv
src/addr_region_decode.sv
src/data_phase_route.sv
src/default_slave.sv
src/ahb_decoder_stage.sv
verif/ahb_decoder_stage_sva.sv
verif/tb_ahb_decoder_stage.sv

//--- run.sh
#!/bin/sh
# Build and run the decoder stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f src.f --top-module tb_ahb_decoder_stage -o tb_sim \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
